/* hdl/soc_pkg.sv */
package soc_pkg;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [3:0]  strb_t;
	typedef logic [1:0]  resp_t;

	localparam resp_t RESP_OKAY   = 2'b00;
	localparam resp_t RESP_SLVERR = 2'b10;
	localparam resp_t RESP_DECERR = 2'b11;

	// Master to target
	typedef struct packed {
		logic  ar_valid;
		addr_t ar_addr;
		logic  aw_valid;
		addr_t aw_addr;
		logic  w_valid;
		data_t w_data;
		strb_t w_strb;
		logic  r_ready;
		logic  b_ready;
	} axi_req_t;

	// Target to master
	typedef struct packed {
		logic  ar_ready;
		logic  aw_ready;
		logic  w_ready;
		logic  r_valid;
		data_t r_data;
		resp_t r_resp;
		logic  b_valid;
		resp_t b_resp;
	} axi_rsp_t;

	// Address map, mask covers the offset bits of each window
	localparam addr_t ROM_BASE    = 32'h0000_0000;
	localparam addr_t ROM_MASK    = 32'h0000_3FFF;
	localparam addr_t SRAM_BASE   = 32'h0001_0000;
	localparam addr_t SRAM_MASK   = 32'h0000_FFFF;
	localparam addr_t SENSOR_BASE = 32'h1000_0000;
	localparam addr_t SENSOR_MASK = 32'h0000_0FFF;

	localparam logic [11:0] SENSOR_CTRL_OFS   = 12'h000;
	localparam logic [11:0] SENSOR_STATUS_OFS = 12'h004;
	localparam logic [11:0] SENSOR_BUF_OFS    = 12'h100;

	// Word address width on the ROM pins
	localparam int ROM_ADDR_W = 14;

endpackage

/* hdl/axi_interconnect.sv */
`timescale 1ns/1ps

module axi_interconnect (
	input  logic              clk,
	input  logic              rst,
	input  soc_pkg::axi_req_t bus_req,
	output soc_pkg::axi_rsp_t bus_rsp,
	output soc_pkg::axi_req_t rom_req,
	input  soc_pkg::axi_rsp_t rom_rsp,
	output soc_pkg::axi_req_t sram_req,
	input  soc_pkg::axi_rsp_t sram_rsp,
	output soc_pkg::axi_req_t sensor_req,
	input  soc_pkg::axi_rsp_t sensor_rsp
);
	import soc_pkg::*;

	localparam logic [1:0] TGT_ROM    = 2'd0;
	localparam logic [1:0] TGT_SRAM   = 2'd1;
	localparam logic [1:0] TGT_SENSOR = 2'd2;
	localparam logic [1:0] TGT_NONE   = 2'd3;

	logic [1:0] ar_sel;
	logic [1:0] aw_sel;
	logic [1:0] rd_tgt;
	logic [1:0] wr_tgt;
	logic       rd_busy;
	logic       wr_busy;
	logic       rd_fire;
	logic       wr_fire;
	axi_rsp_t   dec_rsp;
	axi_rsp_t   tgt_rsp [4];
	axi_req_t   tgt_req [3];

	function automatic logic [1:0] decode(input addr_t addr);
		if ((addr & ~ROM_MASK) == ROM_BASE)
			return TGT_ROM;
		if ((addr & ~SRAM_MASK) == SRAM_BASE)
			return TGT_SRAM;
		if ((addr & ~SENSOR_MASK) == SENSOR_BASE)
			return TGT_SENSOR;
		return TGT_NONE;
	endfunction

	assign ar_sel = decode(bus_req.ar_addr);
	assign aw_sel = decode(bus_req.aw_addr);

	// Unmapped addresses are accepted here and answered with DECERR
	always_comb begin
		dec_rsp          = '0;
		dec_rsp.ar_ready = 1'b1;
		dec_rsp.aw_ready = 1'b1;
		dec_rsp.w_ready  = 1'b1;
		dec_rsp.r_valid  = rd_busy && (rd_tgt == TGT_NONE);
		dec_rsp.r_resp   = RESP_DECERR;
		dec_rsp.b_valid  = wr_busy && (wr_tgt == TGT_NONE);
		dec_rsp.b_resp   = RESP_DECERR;
	end

	assign tgt_rsp[0] = rom_rsp;
	assign tgt_rsp[1] = sram_rsp;
	assign tgt_rsp[2] = sensor_rsp;
	assign tgt_rsp[3] = dec_rsp;

	// Valids only reach the selected target, readys only the owner of the response
	always_comb begin
		for (int i = 0; i < 3; i++) begin
			tgt_req[i]          = bus_req;
			tgt_req[i].ar_valid = bus_req.ar_valid && !rd_busy && (ar_sel == 2'(i));
			tgt_req[i].aw_valid = bus_req.aw_valid && !wr_busy && (aw_sel == 2'(i));
			tgt_req[i].w_valid  = bus_req.w_valid && !wr_busy && (aw_sel == 2'(i));
			tgt_req[i].r_ready  = bus_req.r_ready && rd_busy && (rd_tgt == 2'(i));
			tgt_req[i].b_ready  = bus_req.b_ready && wr_busy && (wr_tgt == 2'(i));
		end
	end

	assign rom_req    = tgt_req[0];
	assign sram_req   = tgt_req[1];
	assign sensor_req = tgt_req[2];

	always_comb begin
		bus_rsp          = '0;
		bus_rsp.ar_ready = bus_req.ar_valid && !rd_busy && tgt_rsp[ar_sel].ar_ready;
		bus_rsp.aw_ready = bus_req.aw_valid && bus_req.w_valid && !wr_busy
			&& tgt_rsp[aw_sel].aw_ready && tgt_rsp[aw_sel].w_ready;
		bus_rsp.w_ready  = bus_rsp.aw_ready;
		bus_rsp.r_valid  = rd_busy && tgt_rsp[rd_tgt].r_valid;
		bus_rsp.r_data   = tgt_rsp[rd_tgt].r_data;
		bus_rsp.r_resp   = tgt_rsp[rd_tgt].r_resp;
		bus_rsp.b_valid  = wr_busy && tgt_rsp[wr_tgt].b_valid;
		bus_rsp.b_resp   = tgt_rsp[wr_tgt].b_resp;
	end

	assign rd_fire = bus_req.ar_valid && bus_rsp.ar_ready;
	assign wr_fire = bus_req.aw_valid && bus_req.w_valid && bus_rsp.aw_ready;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rd_busy <= 1'b0;
			rd_tgt  <= TGT_NONE;
		end else if (rd_fire) begin
			rd_busy <= 1'b1;
			rd_tgt  <= ar_sel;
		end else if (bus_rsp.r_valid && bus_req.r_ready) begin
			rd_busy <= 1'b0;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_busy <= 1'b0;
			wr_tgt  <= TGT_NONE;
		end else if (wr_fire) begin
			wr_busy <= 1'b1;
			wr_tgt  <= aw_sel;
		end else if (bus_rsp.b_valid && bus_req.b_ready) begin
			wr_busy <= 1'b0;
		end
	end

endmodule

/* hdl/rom_bridge.sv */
`timescale 1ns/1ps

module rom_bridge (
	input  logic                           clk,
	input  logic                           rst,
	input  soc_pkg::axi_req_t              req,
	output soc_pkg::axi_rsp_t              rsp,
	output logic                           rom_enable,
	output logic                           rom_read,
	output logic [soc_pkg::ROM_ADDR_W-1:0] rom_address,
	input  soc_pkg::data_t                 rom_out
);
	import soc_pkg::*;

	localparam logic [1:0] ST_IDLE    = 2'd0;
	localparam logic [1:0] ST_ACCESS  = 2'd1;
	localparam logic [1:0] ST_CAPTURE = 2'd2;
	localparam logic [1:0] ST_RESPOND = 2'd3;

	logic [1:0]            state;
	logic [ROM_ADDR_W-1:0] addr_q;
	data_t                 data_q;
	logic                  b_pending;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE:    if (req.ar_valid) state <= ST_ACCESS;
				ST_ACCESS:  state <= ST_CAPTURE;
				// ROM answers one clock after enable
				ST_CAPTURE: state <= ST_RESPOND;
				ST_RESPOND: if (req.r_ready) state <= ST_IDLE;
				default:    state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == ST_IDLE && req.ar_valid)
			addr_q <= req.ar_addr[ROM_ADDR_W+1:2];
		if (state == ST_CAPTURE)
			data_q <= rom_out;
	end

	// ROM is read only, writes never reach the pins
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			b_pending <= 1'b0;
		else if (!b_pending && req.aw_valid && req.w_valid)
			b_pending <= 1'b1;
		else if (b_pending && req.b_ready)
			b_pending <= 1'b0;
	end

	assign rom_enable  = (state == ST_ACCESS);
	assign rom_read    = (state == ST_ACCESS);
	assign rom_address = addr_q;

	always_comb begin
		rsp          = '0;
		rsp.ar_ready = (state == ST_IDLE);
		rsp.r_valid  = (state == ST_RESPOND);
		rsp.r_data   = data_q;
		rsp.r_resp   = RESP_OKAY;
		rsp.aw_ready = !b_pending;
		rsp.w_ready  = !b_pending;
		rsp.b_valid  = b_pending;
		rsp.b_resp   = RESP_SLVERR;
	end

endmodule

/* hdl/sram_slave.sv */
`timescale 1ns/1ps

module sram_slave #(
	parameter int SRAM_WORDS = 1024
) (
	input  logic              clk,
	input  logic              rst,
	input  soc_pkg::axi_req_t req,
	output soc_pkg::axi_rsp_t rsp
);
	import soc_pkg::*;

	localparam int IDX_W = $clog2(SRAM_WORDS);

	data_t            mem [SRAM_WORDS];
	data_t            rdata_q;
	logic             r_pending;
	logic             b_pending;
	logic             rd_fire;
	logic             wr_fire;
	logic [IDX_W-1:0] rd_idx;
	logic [IDX_W-1:0] wr_idx;

	// Word index inside the window, upper bits alias
	assign rd_idx  = req.ar_addr[IDX_W+1:2];
	assign wr_idx  = req.aw_addr[IDX_W+1:2];
	assign rd_fire = req.ar_valid && !r_pending;
	assign wr_fire = req.aw_valid && req.w_valid && !b_pending;

	always_ff @(posedge clk) begin
		if (wr_fire) begin
			for (int b = 0; b < 4; b++) begin
				if (req.w_strb[b])
					mem[wr_idx][8*b +: 8] <= req.w_data[8*b +: 8];
			end
		end
		if (rd_fire)
			rdata_q <= mem[rd_idx];
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			r_pending <= 1'b0;
			b_pending <= 1'b0;
		end else begin
			if (rd_fire)
				r_pending <= 1'b1;
			else if (r_pending && req.r_ready)
				r_pending <= 1'b0;
			if (wr_fire)
				b_pending <= 1'b1;
			else if (b_pending && req.b_ready)
				b_pending <= 1'b0;
		end
	end

	always_comb begin
		rsp          = '0;
		rsp.ar_ready = !r_pending;
		rsp.r_valid  = r_pending;
		rsp.r_data   = rdata_q;
		rsp.r_resp   = RESP_OKAY;
		rsp.aw_ready = !b_pending;
		rsp.w_ready  = !b_pending;
		rsp.b_valid  = b_pending;
		rsp.b_resp   = RESP_OKAY;
	end

endmodule

/* hdl/sensor_bridge.sv */
`timescale 1ns/1ps

module sensor_bridge #(
	parameter int SENSOR_WORDS = 8
) (
	input  logic              clk,
	input  logic              rst,
	input  soc_pkg::axi_req_t req,
	output soc_pkg::axi_rsp_t rsp,
	input  logic              sensor_ready,
	input  soc_pkg::data_t    sensor_out,
	output logic              sensor_en,
	output logic              sensor_irq
);
	import soc_pkg::*;

	localparam int IDX_W = $clog2(SENSOR_WORDS);
	localparam int CNT_W = $clog2(SENSOR_WORDS + 1);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(SENSOR_WORDS - 1);
	localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(SENSOR_WORDS);

	logic             ready_q;
	data_t            word_q;
	logic             en_q;
	logic             irq_q;
	logic             last_q;
	logic [CNT_W-1:0] cnt;
	data_t            cap_buf [SENSOR_WORDS];
	data_t            rd_word;
	data_t            rdata_q;
	logic             r_pending;
	logic             b_pending;
	logic             rd_fire;
	logic             wr_fire;
	logic             ctrl_wr;
	logic             store;
	logic [11:0]      rd_ofs;

	assign rd_fire = req.ar_valid && !r_pending;
	assign wr_fire = req.aw_valid && req.w_valid && !b_pending;
	assign rd_ofs  = req.ar_addr[11:0];
	assign ctrl_wr = wr_fire && (req.aw_addr[11:0] == SENSOR_CTRL_OFS) && req.w_strb[0];
	assign store   = en_q && ready_q;

	// Sensor pins are registered before use
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ready_q <= 1'b0;
			word_q  <= '0;
		end else begin
			ready_q <= sensor_ready;
			word_q  <= sensor_out;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			en_q   <= 1'b0;
			irq_q  <= 1'b0;
			last_q <= 1'b0;
			cnt    <= '0;
		end else begin
			last_q <= store && (cnt == CNT_LAST);
			if (last_q)
				irq_q <= 1'b1;
			if (store) begin
				cnt <= cnt + 1'b1;
				if (cnt == CNT_LAST)
					en_q <= 1'b0;
			end
			// bit 1 acknowledges the interrupt and empties the buffer
			if (ctrl_wr && req.w_data[1]) begin
				cnt   <= '0;
				irq_q <= 1'b0;
			end
			if (ctrl_wr && req.w_data[0] && (req.w_data[1] || cnt != CNT_FULL))
				en_q <= 1'b1;
		end
	end

	always_comb begin
		rd_word = '0;
		if (rd_ofs == SENSOR_CTRL_OFS) begin
			rd_word[0] = en_q;
		end else if (rd_ofs == SENSOR_STATUS_OFS) begin
			rd_word[0]          = irq_q;
			rd_word[8 +: CNT_W] = cnt;
		end else if ((rd_ofs & 12'hF00) == SENSOR_BUF_OFS) begin
			rd_word = cap_buf[rd_ofs[IDX_W+1:2]];
		end
	end

	always_ff @(posedge clk) begin
		if (store)
			cap_buf[cnt[IDX_W-1:0]] <= word_q;
		if (rd_fire)
			rdata_q <= rd_word;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			r_pending <= 1'b0;
			b_pending <= 1'b0;
		end else begin
			if (rd_fire)
				r_pending <= 1'b1;
			else if (r_pending && req.r_ready)
				r_pending <= 1'b0;
			if (wr_fire)
				b_pending <= 1'b1;
			else if (b_pending && req.b_ready)
				b_pending <= 1'b0;
		end
	end

	assign sensor_en  = en_q;
	assign sensor_irq = irq_q;

	always_comb begin
		rsp          = '0;
		rsp.ar_ready = !r_pending;
		rsp.r_valid  = r_pending;
		rsp.r_data   = rdata_q;
		rsp.r_resp   = RESP_OKAY;
		rsp.aw_ready = !b_pending;
		rsp.w_ready  = !b_pending;
		rsp.b_valid  = b_pending;
		rsp.b_resp   = RESP_OKAY;
	end

endmodule

/* hdl/soc_top.sv */
`timescale 1ns/1ps

module soc_top #(
	parameter int SRAM_WORDS   = 1024,
	parameter int SENSOR_WORDS = 8
) (
	input  logic                           clk,
	input  logic                           rst,
	input  soc_pkg::axi_req_t              bus_req,
	output soc_pkg::axi_rsp_t              bus_rsp,
	output logic                           rom_enable,
	output logic                           rom_read,
	output logic [soc_pkg::ROM_ADDR_W-1:0] rom_address,
	input  soc_pkg::data_t                 rom_out,
	input  logic                           sensor_ready,
	input  soc_pkg::data_t                 sensor_out,
	output logic                           sensor_en,
	output logic                           sensor_irq
);
	import soc_pkg::*;

	axi_req_t rom_req;
	axi_rsp_t rom_rsp;
	axi_req_t sram_req;
	axi_rsp_t sram_rsp;
	axi_req_t sensor_req;
	axi_rsp_t sensor_rsp;

	axi_interconnect i_interconnect (
		.clk        (clk),
		.rst        (rst),
		.bus_req    (bus_req),
		.bus_rsp    (bus_rsp),
		.rom_req    (rom_req),
		.rom_rsp    (rom_rsp),
		.sram_req   (sram_req),
		.sram_rsp   (sram_rsp),
		.sensor_req (sensor_req),
		.sensor_rsp (sensor_rsp)
	);

	rom_bridge i_rom (
		.clk         (clk),
		.rst         (rst),
		.req         (rom_req),
		.rsp         (rom_rsp),
		.rom_enable  (rom_enable),
		.rom_read    (rom_read),
		.rom_address (rom_address),
		.rom_out     (rom_out)
	);

	sram_slave #(
		.SRAM_WORDS (SRAM_WORDS)
	) i_sram (
		.clk (clk),
		.rst (rst),
		.req (sram_req),
		.rsp (sram_rsp)
	);

	sensor_bridge #(
		.SENSOR_WORDS (SENSOR_WORDS)
	) i_sensor (
		.clk          (clk),
		.rst          (rst),
		.req          (sensor_req),
		.rsp          (sensor_rsp),
		.sensor_ready (sensor_ready),
		.sensor_out   (sensor_out),
		.sensor_en    (sensor_en),
		.sensor_irq   (sensor_irq)
	);

endmodule

/* verification/clock_gen.sv */
`timescale 1ns/1ps

module clock_gen #(
	parameter int HALF_PERIOD  = 20,
	parameter int RESET_CYCLES = 3
) (
	output logic clk,
	output logic rst
);
	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

/* verification/tb_soc.sv */
`timescale 1ns/1ps

module tb_soc;
	import soc_pkg::*;

	localparam int SRAM_WORDS   = 1024;
	localparam int SENSOR_WORDS = 8;
	localparam string STIM_FILE = "verification/soc_stimulus.txt";

	typedef struct packed {
		logic [7:0] op;
		addr_t      addr;
		data_t      data;
		strb_t      strb;
		data_t      exp_data;
		resp_t      exp_resp;
	} stim_t;

	logic                  clk;
	logic                  rst;
	axi_req_t              bus_req;
	axi_rsp_t              bus_rsp;
	logic                  rom_enable;
	logic                  rom_read;
	logic [ROM_ADDR_W-1:0] rom_address;
	data_t                 rom_out;
	logic                  sensor_ready;
	data_t                 sensor_out;
	logic                  sensor_en;
	logic                  sensor_irq;

	stim_t       ops[$];
	data_t       fed_words[$];
	logic [31:0] lcg_state;
	int          checks;
	int          errors;
	int          limit;
	int          cycles;

	clock_gen i_clock_gen (
		.clk (clk),
		.rst (rst)
	);

	soc_top #(
		.SRAM_WORDS   (SRAM_WORDS),
		.SENSOR_WORDS (SENSOR_WORDS)
	) i_dut (
		.clk          (clk),
		.rst          (rst),
		.bus_req      (bus_req),
		.bus_rsp      (bus_rsp),
		.rom_enable   (rom_enable),
		.rom_read     (rom_read),
		.rom_address  (rom_address),
		.rom_out      (rom_out),
		.sensor_ready (sensor_ready),
		.sensor_out   (sensor_out),
		.sensor_en    (sensor_en),
		.sensor_irq   (sensor_irq)
	);

	// External ROM answers one clock after a read enable
	initial begin
		rom_out = '0;
		forever begin
			@(posedge clk);
			if (rom_enable && rom_read)
				rom_out <= {{(32-ROM_ADDR_W){1'b0}}, rom_address} ^ 32'hA5A5_0000;
		end
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Mismatch %s: got 0x%08h, expected 0x%08h at %0t", name, actual,
				expected, $time);
		end
	endtask

	task automatic read_bus(input addr_t addr, output data_t data, output resp_t resp);
		@(posedge clk);
		bus_req.ar_valid <= 1'b1;
		bus_req.ar_addr  <= addr;
		bus_req.r_ready  <= 1'b1;
		@(negedge clk);
		while (!bus_rsp.ar_ready)
			@(negedge clk);
		@(posedge clk);
		bus_req.ar_valid <= 1'b0;
		@(negedge clk);
		while (!bus_rsp.r_valid)
			@(negedge clk);
		data = bus_rsp.r_data;
		resp = bus_rsp.r_resp;
		@(posedge clk);
		bus_req.r_ready <= 1'b0;
	endtask

	task automatic write_bus(input addr_t addr, input data_t data, input strb_t strb,
		output resp_t resp, output logic rom_seen);
		rom_seen = 1'b0;
		@(posedge clk);
		bus_req.aw_valid <= 1'b1;
		bus_req.aw_addr  <= addr;
		bus_req.w_valid  <= 1'b1;
		bus_req.w_data   <= data;
		bus_req.w_strb   <= strb;
		bus_req.b_ready  <= 1'b1;
		@(negedge clk);
		while (!(bus_rsp.aw_ready && bus_rsp.w_ready)) begin
			rom_seen = rom_seen | rom_enable;
			@(negedge clk);
		end
		@(posedge clk);
		bus_req.aw_valid <= 1'b0;
		bus_req.w_valid  <= 1'b0;
		@(negedge clk);
		while (!bus_rsp.b_valid) begin
			rom_seen = rom_seen | rom_enable;
			@(negedge clk);
		end
		rom_seen = rom_seen | rom_enable;
		resp = bus_rsp.b_resp;
		@(posedge clk);
		bus_req.b_ready <= 1'b0;
	endtask

	// Feed one buffer of LCG words, then read the buffer back
	task automatic fill_sensor(input stim_t s);
		data_t rdata;
		resp_t resp;
		fed_words.delete();
		@(negedge clk);
		check_value("sensor_en", 32'(sensor_en), 32'h1);
		for (int i = 0; i < SENSOR_WORDS; i++) begin
			lcg_state = lcg_next(lcg_state);
			fed_words.push_back(lcg_state);
			@(posedge clk);
			sensor_ready <= 1'b1;
			sensor_out   <= lcg_state;
		end
		@(posedge clk);
		sensor_ready <= 1'b0;
		@(negedge clk);
		while (!sensor_irq)
			@(negedge clk);
		check_value("sensor_irq_en", {30'b0, sensor_irq, sensor_en}, s.exp_data);
		for (int i = 0; i < SENSOR_WORDS; i++) begin
			read_bus(s.addr + 32'(4 * i), rdata, resp);
			check_value("r_data", rdata, fed_words[i]);
			check_value("r_resp", 32'(resp), 32'(s.exp_resp));
		end
	endtask

	task automatic run_op(input stim_t s);
		data_t rdata;
		resp_t resp;
		logic  rom_seen;
		case (s.op)
			"W", "C": begin
				write_bus(s.addr, s.data, s.strb, resp, rom_seen);
				check_value("b_resp", 32'(resp), 32'(s.exp_resp));
				check_value("rom_enable", 32'(rom_seen), 32'h0);
				if (s.op == "C") begin
					@(negedge clk);
					check_value("sensor_irq_en", {30'b0, sensor_irq, sensor_en}, s.exp_data);
				end
			end
			"R": begin
				read_bus(s.addr, rdata, resp);
				check_value("r_data", rdata, s.exp_data);
				check_value("r_resp", 32'(resp), 32'(s.exp_resp));
			end
			"S": fill_sensor(s);
			default: begin
				errors++;
				$display("Unknown operation '%c' in the stimulus file", s.op);
			end
		endcase
	endtask

	task automatic load_stimulus();
		int          fd;
		int          n;
		string       line;
		stim_t       s;
		logic [7:0]  f_op;
		logic [31:0] f_addr;
		logic [31:0] f_data;
		logic [31:0] f_strb;
		logic [31:0] f_exp;
		logic [31:0] f_resp;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			errors++;
			$display("Cannot open the stimulus file %s", STIM_FILE);
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line.getc(0) == "#")
				continue;
			n = $sscanf(line, "%c %h %h %h %h %h", f_op, f_addr, f_data, f_strb, f_exp, f_resp);
			if (n != 6) begin
				errors++;
				$display("Stimulus line could not be parsed: %s", line);
				continue;
			end
			s.op       = f_op;
			s.addr     = f_addr;
			s.data     = f_data;
			s.strb     = f_strb[3:0];
			s.exp_data = f_exp;
			s.exp_resp = f_resp[1:0];
			ops.push_back(s);
		end
		$fclose(fd);
	endtask

	initial begin
		cycles = 0;
		wait (limit > 0);
		while (cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout after %0d cycles, the bus or the sensor never answered", limit);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		bus_req      = '0;
		sensor_ready = 1'b0;
		sensor_out   = '0;
		checks       = 0;
		errors       = 0;
		lcg_state    = 32'h126e_5563;
		load_stimulus();
		limit = ops.size() * 64 + SENSOR_WORDS * 8;
		@(negedge rst);
		@(negedge clk);
		check_value("sensor_en", 32'(sensor_en), 32'h0);
		check_value("sensor_irq", 32'(sensor_irq), 32'h0);
		check_value("rom_enable", 32'(rom_enable), 32'h0);
		check_value("rom_read", 32'(rom_read), 32'h0);
		check_value("r_valid", 32'(bus_rsp.r_valid), 32'h0);
		check_value("b_valid", 32'(bus_rsp.b_valid), 32'h0);
		foreach (ops[i])
			run_op(ops[i]);
		repeat (2) @(posedge clk);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

/* build.f */
hdl/soc_pkg.sv
hdl/axi_interconnect.sv
hdl/rom_bridge.sv
hdl/sram_slave.sv
hdl/sensor_bridge.sv
hdl/soc_top.sv
verification/clock_gen.sv
verification/tb_soc.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the SoC testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -j 0 --top-module tb_soc -f build.f -o tb_soc
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_soc > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
	exit 1
fi
exit 0

/* verification/soc_stimulus.txt */
# op addr data strb exp_data exp_resp, all hex; R read, W write
# C control write and S sensor fill check exp_data against {sensor_irq, sensor_en}
W 00010000 11223344 f 00000000 0
W 00010004 aabbccdd f 00000000 0
W 00010004 00005500 2 00000000 0
W 00010000 99000000 8 00000000 0
W 00010008 deadbeef f 00000000 0
W 00010008 12345678 5 00000000 0
W 00010ffc cafef00d f 00000000 0
W 00010ffc 00001234 3 00000000 0
R 00010000 00000000 0 99223344 0
R 00010004 00000000 0 aabb55dd 0
R 00010008 00000000 0 de34be78 0
R 00010ffc 00000000 0 cafe1234 0
R 00000010 00000000 0 a5a50004 0
R 00000100 00000000 0 a5a50040 0
R 00003ffc 00000000 0 a5a50fff 0
W 00000020 12345678 f 00000000 2
R 00000020 00000000 0 a5a50008 0
R 20000000 00000000 0 00000000 3
R 00004000 00000000 0 00000000 3
W 00020000 12345678 f 00000000 3
R 10000004 00000000 0 00000000 0
C 10000000 00000001 f 00000001 0
S 10000100 00000000 0 00000002 0
R 10000004 00000000 0 00000801 0
W 10000004 ffffffff f 00000000 0
R 10000004 00000000 0 00000801 0
C 10000000 00000002 f 00000000 0
R 10000004 00000000 0 00000000 0
